// ==== dma_realign_pkg.sv ====
// Shared widths, word lane types and port structs for the DMA write realigner.
// Import into any block that needs a qword, a strobe or a transfer command.

`default_nettype none

package dma_realign_pkg;

    localparam int WORD_BITS       = 16; // one word lane
    localparam int WORDS_PER_QWORD = 4;  // lanes per output qword
    localparam int WCNT_BITS       = 12; // transfer word counter

    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [2*WORD_BITS-1:0]     dword_t;   // host side input
    typedef word_t [WORDS_PER_QWORD-1:0] qword_t;  // lane 0 in low bits
    typedef logic [WORDS_PER_QWORD-1:0] wstb_t;    // bit n marks lane n
    typedef logic [1:0]                 word_ptr_t; // lane index
    typedef logic [WCNT_BITS-1:0]       wcnt_t;

    // transfer command with 0-based wcnt (0 means one word)
    typedef struct packed {
        logic      start;
        wcnt_t     wcnt;
        word_ptr_t woffs; // first lane used in the first qword
    } xfer_cmd_t;

    // realigner to output stage
    typedef struct packed {
        logic   valid;
        qword_t data;
        wstb_t  wstb;
        logic   last;  // final beat of the transfer
    } qword_beat_t;

    // registered output towards the qword sink
    typedef struct packed {
        logic   we;
        qword_t data;
        wstb_t  wstb;
    } out_beat_t;

endpackage

`default_nettype wire

// ==== dword_buffer.sv ====
// Input dword FIFO of the realigner. Dwords go alternately to a low and a
// high bank, a complete pair is offered as one qword at the head. Each pop
// frees two dword slots and returns two credits to the source.

`timescale 1ns/100ps
`default_nettype none

module dword_buffer #(
    parameter int BUF_DWORDS = 16
) (
    input  logic                    hclk,
    input  logic                    reset,
    input  logic                    init,
    input  dma_realign_pkg::dword_t din,
    input  logic                    din_valid,
    input  logic                    pop,
    output dma_realign_pkg::qword_t head,
    output logic                    head_valid,
    output logic                    din_credit
);
    import dma_realign_pkg::*;

    localparam int PAIRS = BUF_DWORDS / 2;
    localparam int ABITS = $clog2(PAIRS);

    dword_t           bank_lo [PAIRS]; // even dwords, low half of qword
    dword_t           bank_hi [PAIRS]; // odd dwords
    logic [ABITS+1:0] waddr;           // [0] bank select, top bit is wrap
    logic [ABITS:0]   raddr;           // pair pointer plus wrap
    logic [ABITS-1:0] wslot;
    logic [ABITS-1:0] rslot;

    assign wslot = waddr[ABITS:1];
    assign rslot = raddr[ABITS-1:0];

    // pair is complete once the write side has moved past it
    assign head_valid = (waddr[ABITS+1:1] != raddr);
    assign head       = {bank_hi[rslot], bank_lo[rslot]};

    always_ff @(posedge hclk) begin
        if (reset || init) begin
            waddr <= '0;
        end else if (din_valid) begin
            waddr <= waddr + (ABITS+2)'(1); // next dword slot
        end
    end

    always_ff @(posedge hclk) begin
        if (din_valid && !waddr[0]) begin
            bank_lo[wslot] <= din;
        end
        if (din_valid && waddr[0]) begin
            bank_hi[wslot] <= din;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset || init) begin
            raddr <= '0;
        end else if (pop) begin
            raddr <= raddr + (ABITS+1)'(1);
        end
    end

    // one pulse per freed pair is two credits upstream
    always_ff @(posedge hclk) begin
        if (reset || init) begin
            din_credit <= 1'b0;
        end else begin
            din_credit <= pop;
        end
    end

endmodule

`default_nettype wire

// ==== word_realigner.sv ====
// Word realigner core. Reads qwords from the dword buffer head, keeps the top
// three words of the last popped qword as carry, and builds output qwords
// that start at the command's word offset. Leftover words stay in the carry
// window and open the next transfer.

`timescale 1ns/100ps
`default_nettype none

module word_realigner (
    input  logic                         hclk,
    input  logic                         reset,
    input  logic                         init,
    input  dma_realign_pkg::xfer_cmd_t   cmd,
    input  dma_realign_pkg::qword_t      head,
    input  logic                         head_valid,
    input  logic                         can_send,
    output logic                         pop,
    output dma_realign_pkg::qword_beat_t beat,
    output logic                         busy
);
    import dma_realign_pkg::*;

    word_t [2:0] carry;     // words 1..3 of last popped qword
    word_ptr_t   wp;        // window ptr 0..2 carry word or 3 head word 0
    word_ptr_t   lp;        // first output lane of next beat
    wcnt_t       wcntr;     // remaining words, 0-based
    logic        busy_r;

    word_t [6:0] win;       // carry in 0..2, head in 3..6
    word_ptr_t   wl;        // words left clipped so 3 means four or more
    logic [2:0]  room;      // free lanes from lp up
    logic [2:0]  avail;     // words left, clipped to 4
    logic [2:0]  nwords;    // words consumed by this beat
    logic [2:0]  endp;      // window position after this beat
    logic [2:0]  sel [WORDS_PER_QWORD]; // window index per lane
    wstb_t       stb;
    qword_t      data;
    logic        need_head; // beat reaches into the head qword
    word_ptr_t   nwp;
    logic        fire;
    logic        last;

    assign win = {head, carry};

    // per beat lookup on lane ptr, window ptr and clipped words left
    always_comb begin
        wl     = (wcntr > wcnt_t'(3)) ? 2'd3 : wcntr[1:0];
        room   = 3'd4 - {1'b0, lp};
        avail  = {1'b0, wl} + 3'd1;
        nwords = (avail < room) ? avail : room;
        endp   = {1'b0, wp} + nwords;   // at most 7
        need_head = endp[2];
        nwp    = endp[1:0];             // wraps into new carry past the head
        for (int n = 0; n < WORDS_PER_QWORD; n++) begin
            sel[n] = {1'b0, wp} + 3'(n) - {1'b0, lp};
            stb[n] = (3'(n) >= {1'b0, lp}) && (3'(n) < {1'b0, lp} + nwords);
            if (stb[n]) begin
                data[n] = win[sel[n]];
            end else begin
                data[n] = '0;           // unstrobed lane
            end
        end
    end

    assign last = (wcnt_t'(nwords) > wcntr); // consumed reaches remaining
    assign fire = busy_r && can_send && (head_valid || !need_head);
    assign pop  = fire && need_head;
    assign busy = busy_r;

    always_comb begin
        beat.valid = fire;
        beat.data  = data;
        beat.wstb  = stb;
        beat.last  = last;
    end

    always_ff @(posedge hclk) begin
        if (reset || init) begin
            busy_r <= 1'b0;
            wp     <= 2'd3;             // empty carry, start at head
            lp     <= '0;
            wcntr  <= '0;
        end else if (cmd.start && !busy_r) begin
            busy_r <= 1'b1;
            lp     <= cmd.woffs;
            wcntr  <= cmd.wcnt;
        end else if (fire) begin
            busy_r <= !last;
            wp     <= nwp;
            lp     <= '0;               // later beats start at lane 0
            wcntr  <= wcntr - wcnt_t'(nwords);
        end
    end

    // keep the unread tail of the popped head
    always_ff @(posedge hclk) begin
        if (pop) begin
            carry <= head[3:1];
        end
    end

endmodule

`default_nettype wire

// ==== qword_output.sv ====
// Output stage. Holds the downstream credit count that gates the realigner
// and registers each beat onto the output bus, with done on the last beat.

`timescale 1ns/100ps
`default_nettype none

module qword_output #(
    parameter int OUT_CREDITS = 4
) (
    input  logic                         hclk,
    input  logic                         reset,
    input  dma_realign_pkg::qword_beat_t beat,
    input  logic                         out_credit,
    output logic                         can_send,
    output dma_realign_pkg::out_beat_t   out,
    output logic                         done
);
    import dma_realign_pkg::*;

    localparam int CBITS = $clog2(OUT_CREDITS + 1);

    logic [CBITS-1:0] credits;  // free qword slots downstream
    logic             we_r;
    qword_t           data_r;
    wstb_t            wstb_r;

    assign can_send = (credits != '0);

    always_ff @(posedge hclk) begin
        if (reset) begin
            credits <= CBITS'(OUT_CREDITS);
        end else if (beat.valid && !out_credit) begin
            credits <= credits - CBITS'(1);
        end else if (out_credit && !beat.valid) begin
            credits <= credits + CBITS'(1);
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            we_r <= 1'b0;
            done <= 1'b0;
        end else begin
            we_r <= beat.valid;
            done <= beat.valid && beat.last; // same cycle as the last we
        end
    end

    always_ff @(posedge hclk) begin
        if (beat.valid) begin
            data_r <= beat.data;
            wstb_r <= beat.wstb;
        end
    end

    assign out = '{we: we_r, data: data_r, wstb: wstb_r};

endmodule

`default_nettype wire

// ==== dma_wr_realign.sv ====
// Top level of the single clock DMA write realigner. Dword buffer feeds the
// word realigner, which feeds the credit gated qword output stage.

`timescale 1ns/100ps
`default_nettype none

module dma_wr_realign #(
    parameter int BUF_DWORDS  = 16,  // input credits after reset or init
    parameter int OUT_CREDITS = 4    // downstream qword slots
) (
    input  logic                       hclk,
    input  logic                       reset,
    input  logic                       init,
    input  dma_realign_pkg::xfer_cmd_t cmd,
    input  dma_realign_pkg::dword_t    din,
    input  logic                       din_valid,
    output logic                       din_credit,
    input  logic                       out_credit,
    output dma_realign_pkg::out_beat_t out,
    output logic                       done,
    output logic                       busy
);
    import dma_realign_pkg::*;

    qword_t      head;
    logic        head_valid;
    logic        pop;
    qword_beat_t beat;
    logic        can_send;

    dword_buffer #(
        .BUF_DWORDS (BUF_DWORDS)
    ) i_dword_buffer (
        .hclk       (hclk),
        .reset      (reset),
        .init       (init),
        .din        (din),
        .din_valid  (din_valid),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .din_credit (din_credit)
    );

    word_realigner i_word_realigner (
        .hclk       (hclk),
        .reset      (reset),
        .init       (init),
        .cmd        (cmd),
        .head       (head),
        .head_valid (head_valid),
        .can_send   (can_send),
        .pop        (pop),
        .beat       (beat),
        .busy       (busy)
    );

    qword_output #(
        .OUT_CREDITS (OUT_CREDITS)
    ) i_qword_output (
        .hclk       (hclk),
        .reset      (reset),
        .beat       (beat),
        .out_credit (out_credit),
        .can_send   (can_send),
        .out        (out),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== tb_dma_wr_realign.sv ====
// Testbench for the DMA write realigner. A random dword source and a
// credit returning sink run around the DUT, and a word queue model
// predicts every strobe, data lane and done.
// Phases are aligned, random, odd counts, slow sink and init flush.

`timescale 1ns/100ps
`default_nettype none

module tb_dma_wr_realign;
    import dma_realign_pkg::*;

    localparam int BUF_DWORDS  = 16;
    localparam int OUT_CREDITS = 4;
    localparam int NX     = 58; // transfers in total
    localparam int P_RAND = 6;  // first transfer of each phase
    localparam int P_ODD  = 30;
    localparam int P_SLOW = 42;
    localparam int P_INIT = 52;

    logic      hclk = 1'b0;
    logic      reset, init, din_credit, done, busy;
    logic      din_valid = 1'b0;
    logic      out_credit = 1'b0;
    dword_t    din = '0;
    xfer_cmd_t cmd;
    out_beat_t out;

    logic [31:0] lfsr;
    word_t       model_q[$];   // words sent, not yet seen on out
    wcnt_t       plan_wcnt[NX];
    word_ptr_t   plan_woffs[NX];
    logic [1:0]  plan_gap[NX]; // idle cycles before each start
    string       test_name;
    bit          run_on, src_on, bursty, slow_sink, xfer_active;
    int          src_credits, dut_credits, buf_fill, owed, gap_cnt, sink_wait;
    int          exp_lane, exp_left, done_count, cycles, cycle_limit, total_words;

    dma_wr_realign #(.BUF_DWORDS(BUF_DWORDS), .OUT_CREDITS(OUT_CREDITS)) i_dut (
        .hclk(hclk), .reset(reset), .init(init), .cmd(cmd),
        .din(din), .din_valid(din_valid), .din_credit(din_credit),
        .out_credit(out_credit), .out(out), .done(done), .busy(busy)
    );

    initial forever #50 hclk = ~hclk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_error(input string why);
        $display("Error in %s: %s", test_name, why);
        stop_run();
    endtask

    task automatic check_wstb(input wstb_t exp, input wstb_t act);
        if (exp !== act) begin
            $display("** Error: %s: wstb expected %h, actual %h", test_name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_word(input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error: %s: word expected %h, actual %h", test_name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_done(input bit exp, input bit act);
        if (exp !== act) begin
            $display("** Error: %s: done expected %0b, actual %0b", test_name, exp, act);
            stop_run();
        end
    endtask

    // one output beat against the word queue
    task automatic check_beat();
        int    n;
        wstb_t exp_stb;
        n = (exp_left < 4 - exp_lane) ? exp_left : 4 - exp_lane; // words left vs free lanes
        exp_stb = wstb_t'(((1 << n) - 1) << exp_lane);
        check_wstb(exp_stb, out.wstb);
        for (int l = 0; l < WORDS_PER_QWORD; l++) begin
            if (exp_stb[l] && model_q.size() == 0) begin
                report_error("DUT wrote a word that the source never sent");
            end else if (exp_stb[l]) begin
                check_word(model_q.pop_front(), out.data[l]);
            end
        end
        exp_left -= n;
        exp_lane  = 0;              // later beats start at lane 0
        check_done(exp_left == 0, done);
        if (done && busy) report_error("busy still high together with done");
        if (done) begin
            xfer_active = 1'b0;
            done_count++;
        end
    endtask

    // dword source and credit returning sink
    always @(posedge hclk) begin : src_sink
        logic [31:0] d;
        bit          send;
        send = 1'b0;
        if (run_on && src_on && src_credits > 0) begin
            if (!bursty) begin
                send = (rand_bits(2) != 0);
            end else if (gap_cnt > 0) begin
                gap_cnt--;
            end else begin
                send = 1'b1;
                if (rand_bits(2) == 0) gap_cnt = int'(rand_bits(4)); // pause the burst
            end
        end
        if (send) begin
            d = rand_bits(32);
            din       <= d;
            din_valid <= 1'b1;
            src_credits--;
            model_q.push_back(d[15:0]);  // low word first
            model_q.push_back(d[31:16]);
        end else begin
            din_valid <= 1'b0;
        end
        if (run_on && owed > 0 && sink_wait == 0) begin
            out_credit <= 1'b1;
            owed--;
            sink_wait = slow_sink ? int'(rand_bits(3)) + 4 : int'(rand_bits(1));
        end else begin
            out_credit <= 1'b0;
            if (sink_wait > 0) sink_wait--;
        end
    end

    // monitor samples away from the driving edge
    always @(negedge hclk) begin
        if (run_on) begin
            cycles++;
            if (cycles > cycle_limit) report_error("timeout, transfers did not finish");
            if (din_valid) buf_fill++;
            if (din_credit) begin
                buf_fill    -= 2;
                src_credits += 2;  // one pulse is two credits
            end
            if (out_credit) dut_credits++;
            if (out.we) begin
                dut_credits--;
                owed++;
                if (dut_credits < 0) report_error("output write without a credit");
                if (!xfer_active) report_error("output write with no transfer running");
                check_beat();
            end else if (done) begin
                report_error("done without an output write");
            end
            // unread words sit in the buffer or in at most three carry words
            if (buf_fill < 0 || model_q.size() > 2 * buf_fill + 3) begin
                report_error("source sent more dwords than the buffer has room for");
            end
        end
    end

    task automatic run_xfer(input wcnt_t wc, input word_ptr_t wo);
        @(posedge hclk);
        cmd <= '{start: 1'b1, wcnt: wc, woffs: wo};
        exp_lane    = int'(wo);
        exp_left    = int'(wc) + 1;
        xfer_active = 1'b1;
        @(posedge hclk);
        cmd.start <= 1'b0;
        while (xfer_active) begin
            @(posedge hclk);
        end
    endtask

    // pause the source, pulse init, restart from an empty model
    task automatic flush_with_init();
        src_on <= 1'b0;
        repeat (4) @(posedge hclk);
        init <= 1'b1;
        @(posedge hclk);
        init <= 1'b0;
        model_q.delete();
        src_credits = BUF_DWORDS;
        buf_fill    = 0;
        src_on <= 1'b1;
    endtask

    initial begin
        reset <= 1'b1;
        init  <= 1'b0;
        cmd   <= '0;
        lfsr = 32'h4eeb_8df7;
        src_credits = BUF_DWORDS;
        dut_credits = OUT_CREDITS;
        for (int i = 0; i < NX; i++) begin
            plan_gap[i] = 2'(rand_bits(2));
            plan_woffs[i] = (i < P_RAND) ? word_ptr_t'(0) : word_ptr_t'(rand_bits(2));
            if (i < P_RAND) begin
                plan_wcnt[i] = wcnt_t'(4 * rand_bits(3) + 3);  // 4 to 32 words
            end else if (i >= P_ODD && i < P_SLOW) begin
                plan_wcnt[i] = wcnt_t'(2 * rand_bits(4));      // odd word counts
            end else begin
                plan_wcnt[i] = wcnt_t'(rand_bits(6));
            end
            total_words += int'(plan_wcnt[i]) + 1;
        end
        cycle_limit = 40 * total_words + 1000;
        repeat (5) @(posedge hclk);
        reset  <= 1'b0;
        run_on <= 1'b1;
        src_on <= 1'b1;
        for (int i = 0; i < NX; i++) begin
            case (i)
                0:      test_name = "aligned";
                P_RAND: test_name = "random";
                P_ODD:  test_name = "odd_carry";
                P_SLOW: begin
                    test_name = "slow_sink";
                    bursty    <= 1'b1;
                    slow_sink <= 1'b1;
                end
                P_INIT: begin
                    test_name = "init_flush";
                    bursty    <= 1'b0;
                    slow_sink <= 1'b0;
                end
                default: ;
            endcase
            if (i >= P_INIT && (i - P_INIT) % 2 == 0) flush_with_init();
            repeat (plan_gap[i]) @(posedge hclk);
            run_xfer(plan_wcnt[i], plan_woffs[i]);
        end
        repeat (8) @(posedge hclk);
        if (done_count == NX && !xfer_active) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Error: %0d of %0d transfers ended with done", done_count, NX);
            $display("STATUS: FAIL");
            $fatal(1, "transfer count mismatch");
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
dma_realign_pkg.sv
dword_buffer.sv
word_realigner.sv
qword_output.sv
dma_wr_realign.sv
tb_dma_wr_realign.sv

// ==== Makefile ====
# Verilator lint and simulation of the DMA write realigner

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_dma_wr_realign
RTL_TOP   ?= dma_wr_realign
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
